//--- fft_data_pkg.sv
// sample, twiddle, complex and frame types
// twiddle fraction width and W16^k table in Q13

package fft_data_pkg;

    // ********************
    // frame geometry and number formats
    // ********************

    // points per frame
    localparam int N_POINTS = 16;

    // fraction bits of a twiddle, 0x2000 is 1.0
    localparam int TW_FRAC = 13;

    // one real or imaginary part
    typedef logic signed [23:0] sample_t;

    // one twiddle component in Q13
    typedef logic signed [15:0] twiddle_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    // index 0 holds sample 0
    typedef cplx_t [N_POINTS-1:0] frame_t;

    // ********************
    // twiddles W16^k for k = 0..7
    // ********************

    // cos(2*pi*k/16) rounded to Q13
    localparam twiddle_t TW_RE [8] = '{
        16'h2000, 16'h1D90, 16'h16A1, 16'h0C3F,
        16'h0000, 16'hF3C1, 16'hE95F, 16'hE270
    };

    // -sin(2*pi*k/16) rounded to Q13
    localparam twiddle_t TW_IM [8] = '{
        16'h0000, 16'hF3C1, 16'hE95F, 16'hE270,
        16'hE000, 16'hE270, 16'hE95F, 16'hF3C1
    };

endpackage

//--- fft_ctrl_pkg.sv
// sequencer states, stage/pair/address types
// butterfly tag and pipeline latency

package fft_ctrl_pkg;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_DRAIN,
        S_DONE
    } seq_state_t;

    // stage 0..3
    typedef logic [1:0] stage_t;

    // butterfly within a stage, 0..7
    typedef logic [2:0] pair_t;

    // store address
    typedef logic [3:0] addr_t;

    // travels with each butterfly through the pipeline
    typedef struct packed {
        addr_t      addr_a;
        addr_t      addr_b;
        logic [2:0] tw_idx;
    } bfly_tag_t;

    // butterfly pipeline latency in cycles
    localparam int BFLY_LAT = 3;

endpackage

//--- fft_seq.sv
// sequencer FSM for the in-place FFT
// load, eight issues per stage, drain, output handshake

`timescale 1ns/1ns

module fft_seq
    import fft_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    output logic out_valid,
    input  logic out_ready,
    output logic load,
    output logic issue,
    output logic cnt_clear,
    output logic pair_step,
    output logic drain_step,
    input  logic pair_last,
    input  logic drain_last,
    input  logic stage_last
);

    seq_state_t state;
    seq_state_t state_next;
    logic       accept;
    logic       take;

    assign accept = in_valid && in_ready;
    assign take   = out_valid && out_ready;

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    state_next = S_ISSUE;
                end
            end
            S_ISSUE: begin
                if (pair_last) begin
                    state_next = S_DRAIN;
                end
            end
            S_DRAIN: begin
                if (drain_last) begin
                    state_next = stage_last ? S_DONE : S_ISSUE;
                end
            end
            S_DONE: begin
                if (take) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    // out_valid lags S_DONE by one cycle
    // so the last write-back of stage 3 has landed
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= S_IDLE;
            out_valid <= 1'b0;
        end else begin
            state     <= state_next;
            out_valid <= (state == S_DONE) && !take;
        end
    end

    assign in_ready   = (state == S_IDLE);
    assign load       = accept;
    assign cnt_clear  = accept;
    assign issue      = (state == S_ISSUE);
    assign pair_step  = (state == S_ISSUE);
    assign drain_step = (state == S_DRAIN);

endmodule

//--- fft_step_counter.sv
// stage, pair and drain counters
// flags for last pair, last drain cycle and last stage

`timescale 1ns/1ns

module fft_step_counter
    import fft_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   cnt_clear,
    input  logic   pair_step,
    input  logic   drain_step,
    output stage_t stage,
    output pair_t  pair,
    output logic   pair_last,
    output logic   drain_last,
    output logic   stage_last
);

    logic [1:0] drain_cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stage     <= '0;
            pair      <= '0;
            drain_cnt <= '0;
        end else if (cnt_clear) begin
            stage     <= '0;
            pair      <= '0;
            drain_cnt <= '0;
        end else begin
            // pair wraps to 0 after the eighth butterfly
            if (pair_step) begin
                pair <= pair + 1'b1;
            end
            // stage moves on once the pipeline is empty
            if (drain_step) begin
                if (drain_last) begin
                    drain_cnt <= '0;
                    stage     <= stage + 1'b1;
                end else begin
                    drain_cnt <= drain_cnt + 1'b1;
                end
            end
        end
    end

    assign pair_last  = (pair == 3'd7);
    assign drain_last = (drain_cnt == 2'(BFLY_LAT - 1));
    assign stage_last = (stage == 2'd3);

endmodule

//--- fft_sample_store.sv
// 16-entry complex sample store
// bit-reversed load, operand fetch with tag, in-place write-back

`timescale 1ns/1ns

module fft_sample_store
    import fft_data_pkg::*;
    import fft_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load,
    input  frame_t    in_frame,
    input  logic      issue,
    input  stage_t    stage,
    input  pair_t     pair,
    output logic      op_valid,
    output cplx_t     op_a,
    output cplx_t     op_b,
    output bfly_tag_t op_tag,
    input  logic      res_valid,
    input  cplx_t     res_y0,
    input  cplx_t     res_y1,
    input  bfly_tag_t res_tag,
    output frame_t    out_frame
);

    frame_t    mem;
    bfly_tag_t tag_next;
    pair_t     low_mask;
    pair_t     pair_low;
    addr_t     span;

    function automatic addr_t bitrev(input addr_t a);
        return {a[0], a[1], a[2], a[3]};
    endfunction

    // ********************
    // operand addressing
    // ********************

    // span = 2^stage, pair splits into group and offset
    assign span     = addr_t'(1) << stage;
    assign low_mask = pair_t'(span - 1'b1);
    assign pair_low = pair & low_mask;

    always_comb begin
        // group base is group * 2 * span, at full address width
        tag_next.addr_a = ((addr_t'(pair >> stage) << stage) << 1) | addr_t'(pair_low);
        tag_next.addr_b = tag_next.addr_a + span;
        // twiddle W(2*span)^j is W16^(j*8/span)
        tag_next.tw_idx = pair_low << (2'd3 - stage);
    end

    // ********************
    // storage
    // ********************

    always_ff @(posedge clk) begin
        if (load) begin
            for (int k = 0; k < N_POINTS; k++) begin
                mem[bitrev(addr_t'(k))] <= in_frame[k];
            end
        end else if (res_valid) begin
            mem[res_tag.addr_a] <= res_y0;
            mem[res_tag.addr_b] <= res_y1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= issue;
        end
    end

    // operand registers carry no reset
    always_ff @(posedge clk) begin
        if (issue) begin
            op_a   <= mem[tag_next.addr_a];
            op_b   <= mem[tag_next.addr_b];
            op_tag <= tag_next;
        end
    end

    assign out_frame = mem;

endmodule

//--- fft_butterfly.sv
// three-stage pipelined radix-2 butterfly
// twiddle lookup, y0 = a + w*b, y1 = a - w*b

`timescale 1ns/1ns

module fft_butterfly
    import fft_data_pkg::*;
    import fft_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      op_valid,
    input  cplx_t     op_a,
    input  cplx_t     op_b,
    input  bfly_tag_t op_tag,
    output logic      res_valid,
    output cplx_t     res_y0,
    output cplx_t     res_y1,
    output bfly_tag_t res_tag
);

    // full width of a sample times a twiddle
    typedef logic signed [39:0] prod_t;

    twiddle_t  w_re;
    twiddle_t  w_im;

    logic      v_s1;
    logic      v_s2;
    cplx_t     a_s1;
    cplx_t     a_s2;
    bfly_tag_t tag_s1;
    bfly_tag_t tag_s2;
    prod_t     p_rr;
    prod_t     p_ii;
    prod_t     p_ri;
    prod_t     p_ir;
    cplx_t     wb;

    assign w_re = TW_RE[op_tag.tw_idx];
    assign w_im = TW_IM[op_tag.tw_idx];

    // valid chain, no stall
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            v_s1      <= 1'b0;
            v_s2      <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            v_s1      <= op_valid;
            v_s2      <= v_s1;
            res_valid <= v_s2;
        end
    end

    // ********************
    // stage 1: four real products
    // ********************
    always_ff @(posedge clk) begin
        p_rr   <= op_b.re * w_re;
        p_ii   <= op_b.im * w_im;
        p_ri   <= op_b.re * w_im;
        p_ir   <= op_b.im * w_re;
        a_s1   <= op_a;
        tag_s1 <= op_tag;
    end

    // ********************
    // stage 2: truncate and combine into w*b
    // ********************
    always_ff @(posedge clk) begin
        wb.re  <= sample_t'((p_rr >>> TW_FRAC) - (p_ii >>> TW_FRAC));
        wb.im  <= sample_t'((p_ri >>> TW_FRAC) + (p_ir >>> TW_FRAC));
        a_s2   <= a_s1;
        tag_s2 <= tag_s1;
    end

    // ********************
    // stage 3: sum and difference, wrapping to 24 bits
    // ********************
    always_ff @(posedge clk) begin
        res_y0.re <= a_s2.re + wb.re;
        res_y0.im <= a_s2.im + wb.im;
        res_y1.re <= a_s2.re - wb.re;
        res_y1.im <= a_s2.im - wb.im;
        res_tag   <= tag_s2;
    end

endmodule

//--- fft16.sv
// 16-point in-place radix-2 DIT FFT, top level
// sequencer, step counter, sample store and butterfly

`timescale 1ns/1ns

module fft16
    import fft_data_pkg::*;
    import fft_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    output logic   in_ready,
    input  frame_t in_frame,
    output logic   out_valid,
    input  logic   out_ready,
    output frame_t out_frame
);

    // control between sequencer, counter and store
    logic      load;
    logic      issue;
    logic      cnt_clear;
    logic      pair_step;
    logic      drain_step;
    logic      pair_last;
    logic      drain_last;
    logic      stage_last;
    stage_t    stage;
    pair_t     pair;

    // butterfly operands and results
    logic      op_valid;
    cplx_t     op_a;
    cplx_t     op_b;
    bfly_tag_t op_tag;
    logic      res_valid;
    cplx_t     res_y0;
    cplx_t     res_y1;
    bfly_tag_t res_tag;

    fft_seq seq_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .load       (load),
        .issue      (issue),
        .cnt_clear  (cnt_clear),
        .pair_step  (pair_step),
        .drain_step (drain_step),
        .pair_last  (pair_last),
        .drain_last (drain_last),
        .stage_last (stage_last)
    );

    fft_step_counter counter_i (
        .clk        (clk),
        .rst        (rst),
        .cnt_clear  (cnt_clear),
        .pair_step  (pair_step),
        .drain_step (drain_step),
        .stage      (stage),
        .pair       (pair),
        .pair_last  (pair_last),
        .drain_last (drain_last),
        .stage_last (stage_last)
    );

    fft_sample_store store_i (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .in_frame  (in_frame),
        .issue     (issue),
        .stage     (stage),
        .pair      (pair),
        .op_valid  (op_valid),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_tag    (op_tag),
        .res_valid (res_valid),
        .res_y0    (res_y0),
        .res_y1    (res_y1),
        .res_tag   (res_tag),
        .out_frame (out_frame)
    );

    fft_butterfly bfly_i (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_tag    (op_tag),
        .res_valid (res_valid),
        .res_y0    (res_y0),
        .res_y1    (res_y1),
        .res_tag   (res_tag)
    );

endmodule

//--- fft16_tb.sv
// testbench for the 16-point FFT
// frames and expected bins from fft16_golden.txt
// checks latency, held output under back-pressure, in_ready

`timescale 1ns/1ns

module fft16_tb
    import fft_data_pkg::*;
();

    localparam int N_FRAMES       = 3;
    localparam int COLS           = 4;
    // one load cycle, then four stages of eight issues and a three cycle drain
    localparam int EXP_LATENCY    = 1 + 4 * (8 + 3);
    localparam int TIMEOUT_CYCLES = N_FRAMES * (EXP_LATENCY + 64) + 200;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    frame_t      in_frame;
    logic        out_valid;
    logic        out_ready;
    frame_t      out_frame;

    logic [23:0] golden [0:N_FRAMES*N_POINTS*COLS-1];
    int          error_count;
    int          check_count;
    int          cycle_count;
    int unsigned seed;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    fft16 fft16_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_frame  (in_frame),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_frame (out_frame)
    );

    // ********************
    // helpers
    // ********************

    task automatic check_value(input string name, input logic [23:0] expected,
                               input logic [23:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // col 0 gives the input frame, col 2 the expected bins
    function automatic frame_t golden_frame(input int f, input int col);
        frame_t fr;
        for (int k = 0; k < N_POINTS; k++) begin
            fr[k].re = golden[(f * N_POINTS + k) * COLS + col];
            fr[k].im = golden[(f * N_POINTS + k) * COLS + col + 1];
        end
        return fr;
    endfunction

    // returns just after the accepting edge
    task automatic send_frame(input int f);
        logic accepted;
        accepted = 1'b0;
        in_frame = golden_frame(f, 0);
        in_valid = 1'b1;
        while (!accepted) begin
            accepted = in_ready;
            @(posedge clk);
            #5;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_output(input int f);
        int latency;
        latency = 0;
        while (!out_valid) begin
            check_value($sformatf("frame %0d in_ready while busy", f), 24'd0, 24'(in_ready));
            @(posedge clk);
            #5;
            latency++;
        end
        check_value($sformatf("frame %0d latency", f), 24'(EXP_LATENCY), 24'(latency));
    endtask

    task automatic take_output(input int f);
        frame_t expected;
        frame_t held;
        logic   ready_bit;
        logic   taken;
        expected = golden_frame(f, 2);
        held     = out_frame;
        for (int k = 0; k < N_POINTS; k++) begin
            check_value($sformatf("frame %0d bin %0d re", f, k), expected[k].re, held[k].re);
            check_value($sformatf("frame %0d bin %0d im", f, k), expected[k].im, held[k].im);
        end
        // first output cycle always stalls
        taken     = 1'b0;
        ready_bit = 1'b0;
        while (!taken) begin
            out_ready = ready_bit;
            for (int k = 0; k < N_POINTS; k++) begin
                check_value($sformatf("frame %0d held bin %0d re", f, k), held[k].re,
                            out_frame[k].re);
                check_value($sformatf("frame %0d held bin %0d im", f, k), held[k].im,
                            out_frame[k].im);
            end
            check_value($sformatf("frame %0d out_valid held", f), 24'd1, 24'(out_valid));
            check_value($sformatf("frame %0d in_ready held", f), 24'd0, 24'(in_ready));
            @(posedge clk);
            #5;
            taken     = ready_bit;
            ready_bit = 1'($urandom % 2);
        end
        out_ready = 1'b0;
        check_value($sformatf("frame %0d out_valid after take", f), 24'd0, 24'(out_valid));
        check_value($sformatf("frame %0d in_ready after take", f), 24'd1, 24'(in_ready));
    endtask

    // ********************
    // main sequence
    // ********************

    initial begin
        rst         = 1'b0;
        in_valid    = 1'b0;
        in_frame    = '0;
        out_ready   = 1'b0;
        error_count = 0;
        check_count = 0;
        seed        = 32'h41a4_c7c4;
        void'($urandom(seed));
        $readmemh("fft16_golden.txt", golden);
        if ($isunknown(golden[N_FRAMES*N_POINTS*COLS-1])) begin
            $display("golden file fft16_golden.txt is missing or too short");
            error_count++;
        end
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b1;
        check_value("reset out_valid", 24'd0, 24'(out_valid));
        check_value("reset in_ready", 24'd1, 24'(in_ready));
        // frame 0 is the impulse, frames 1 and 2 mixed data
        for (int f = 0; f < N_FRAMES; f++) begin
            send_frame(f);
            wait_output(f);
            take_output(f);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- fft16_golden.txt
// columns: input re, input im, expected output re, expected output im (24-bit hex)
// three frames of 16 lines, line k of a frame is sample k and bin k
001000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
000000 000000 001000 000000
7ff000 800800 801710 7ffc48
002710 fff448 800f9a 7fee39
000000 000000 800356 7fe416
000000 000000 7ff41f 7fdf6c
000000 000000 7fe448 7fe0f0
000000 000000 7fd63a 7fe865
000000 000000 7fcc17 7ff4a9
000000 000000 7fc76d 8003e0
000000 000000 7fc8f0 8013b8
000000 000000 7fd066 8021c7
000000 000000 7fdcaa 802bea
000000 000000 7febe1 803094
000000 000000 7ffbb8 802f10
000000 000000 8009c6 80279b
000000 000000 8013e9 801b57
000000 000000 801893 800c20
fff830 0005dc 000fa0 fff448
000000 ffe4a8 000534 ffe2ed
001770 0009c4 ffee9e ffdb15
000000 000000 ffd543 ffe3ea
000000 000000 ffc568 fffc18
000000 000000 ffc774 0019fe
000000 000000 ffdb16 0030a2
000000 000000 fff765 003699
000000 000000 000fa0 002af8
000000 000000 001a20 001573
000000 000000 00154a 0001c3
000000 000000 0007c7 fff8d8
000000 000000 fffc18 fffc18
000000 000000 fff9f8 000512
000000 000000 0001c2 0009f6
000000 000000 000c51 000415

//--- project.f
fft_data_pkg.sv
fft_ctrl_pkg.sv
fft_seq.sv
fft_step_counter.sv
fft_sample_store.sv
fft_butterfly.sv
fft16.sv
fft16_tb.sv

//--- Bender.yml
package:
  name: fft16
  description: "16-point radix-2 in-place FFT with a pipelined butterfly"

dependencies: {}

sources:
  # packages ahead of the modules that import them
  - files:
      - fft_data_pkg.sv
      - fft_ctrl_pkg.sv
      - fft_seq.sv
      - fft_step_counter.sv
      - fft_sample_store.sv
      - fft_butterfly.sv
      - fft16.sv

  # testbench, reads fft16_golden.txt from the project root
  - target: test
    files:
      - fft16_tb.sv
